/* verilog/motion_defs.svh */
`ifndef MOTION_DEFS_SVH
`define MOTION_DEFS_SVH

// Move buffer geometry
`define MOTION_SLOTS 4  // Queue depth per axis
`define MOTION_AXES  2  // Axis timers sharing the buffer

// Bus sizing
`define MOTION_DW 32  // Data word
`define MOTION_AW 6   // Word address

// Register map above the 32 word RAM
`define MOTION_CTRL_ADR 6'h20  // Ready toggle register
`define MOTION_STAT_ADR 6'h21  // Packed finished vectors

// Accumulator drop per step, 2^30
`define MOTION_STEP_THRESHOLD 32'h4000_0000

`endif

/* verilog/motion_pkg.sv */
`include "motion_defs.svh"

package motion_pkg;

  // Word within one buffer entry
  typedef enum logic [1:0] {
    DURATION  = 2'd0,  // Ticks minus one
    INCREMENT = 2'd1,  // Step rate at move start
    INCINC    = 2'd2,  // Rate change per tick
    UNUSED    = 2'd3   // Spare word
  } field_e;

  // Index into the move queue
  typedef logic [$clog2(`MOTION_SLOTS)-1:0] slot_t;

  // Axis number, one bit for two axes
  typedef logic [$clog2(`MOTION_AXES)-1:0] axis_t;

endpackage

/* verilog/wb_if.sv */
`timescale 1ns/1ps
`include "motion_defs.svh"

// Wishbone classic, single master to single slave
interface wb_if (
  input logic CLK,
  input logic rst_n
);
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [`MOTION_AW-1:0] adr;    // Word address
  logic [`MOTION_DW-1:0] dat_w;
  logic [`MOTION_DW-1:0] dat_r;
  logic                  ack;    // Registered, one cycle per request

  modport master (
    input  CLK, rst_n, dat_r, ack,
    output cyc, stb, we, adr, dat_w
  );

  modport slave (
    input  CLK, rst_n, cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

/* verilog/move_buffer.sv */
`timescale 1ns/1ps
`include "motion_defs.svh"

module move_buffer (
  input  logic                     CLK,
  input  logic                     rst_n,
  wb_if.slave                      bus,
  input  logic [`MOTION_SLOTS-1:0] finished_0,
  input  logic [`MOTION_SLOTS-1:0] finished_1,
  output logic [`MOTION_SLOTS-1:0] ready
);

  localparam int RAM_WORDS = `MOTION_SLOTS * `MOTION_AXES * 4;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  logic [`MOTION_DW-1:0] mem [RAM_WORDS];  // {slot, axis, field} addressed
  logic                  req;              // New request seen this cycle
  logic                  in_ram;

  // Suppress a second ack while the master still holds stb
  assign req    = bus.cyc && bus.stb && !bus.ack;
  assign in_ram = bus.adr < `MOTION_AW'(RAM_WORDS);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      bus.ack <= 1'b0;
      ready   <= '0;
    end else begin
      bus.ack <= req;
      if (req && bus.we && bus.adr == `MOTION_CTRL_ADR) begin
        ready <= ready ^ bus.dat_w[`MOTION_SLOTS-1:0];  // Host toggles slots
      end
    end
  end

  // Move parameter storage
  always_ff @(posedge CLK) begin
    if (req && bus.we && in_ram) begin
      mem[bus.adr[RAM_AW-1:0]] <= bus.dat_w;
    end
  end

  // Read data lands with ack
  always_ff @(posedge CLK) begin
    if (req) begin
      if (in_ram) begin
        bus.dat_r <= mem[bus.adr[RAM_AW-1:0]];
      end else if (bus.adr == `MOTION_CTRL_ADR) begin
        bus.dat_r <= `MOTION_DW'(ready);
      end else if (bus.adr == `MOTION_STAT_ADR) begin
        bus.dat_r <= `MOTION_DW'({finished_1, finished_0});  // Axis 1 on top
      end else begin
        bus.dat_r <= '0;  // Unmapped
      end
    end
  end

  // Requester must still be holding its strobe when ack shows up
  ack_needs_stb : assert property (
    @(posedge CLK) disable iff (!rst_n) bus.ack |-> (bus.cyc && bus.stb)
  ) else $error("move_buffer ack without an open strobe");

endmodule

/* verilog/wb_arbiter.sv */
`timescale 1ns/1ps
`include "motion_defs.svh"

module wb_arbiter (
  input  logic CLK,
  input  logic rst_n,
  wb_if.slave  m0,  // Host
  wb_if.slave  m1,  // Axis 0
  wb_if.slave  m2,  // Axis 1
  wb_if.master s
);

  logic [2:0] req;
  logic [2:0] grant;       // One-hot or idle
  logic [1:0] last;        // Index of the last master served
  logic [2:0] pick;
  logic [1:0] pick_idx;
  logic       grant_open;  // Granted master still in its cycle

  assign req        = {m2.cyc, m1.cyc, m0.cyc};
  assign grant_open = |(grant & req);

  // Round-robin search, starting one past the last winner
  always_comb begin
    logic [1:0] idx;
    pick     = '0;
    pick_idx = last;
    idx      = last;
    for (int i = 1; i <= 3; i++) begin
      idx = 2'((32'(last) + i) % 3);
      if (req[idx] && pick == '0) begin
        pick[idx] = 1'b1;
        pick_idx  = idx;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      grant <= '0;
      last  <= 2'd2;  // Host goes first
    end else if (!grant_open) begin
      grant <= pick;  // Re-arbitrate only between cycles
      if (|pick) begin
        last <= pick_idx;
      end
    end
  end

  // Forward path
  always_comb begin
    s.cyc   = grant_open;
    s.stb   = 1'b0;
    s.we    = 1'b0;
    s.adr   = '0;
    s.dat_w = '0;
    if (grant[0]) begin
      s.stb = m0.cyc && m0.stb;
      s.we = m0.we;
      s.adr = m0.adr;
      s.dat_w = m0.dat_w;
    end else if (grant[1]) begin
      s.stb = m1.cyc && m1.stb;
      s.we = m1.we;
      s.adr = m1.adr;
      s.dat_w = m1.dat_w;
    end else if (grant[2]) begin
      s.stb = m2.cyc && m2.stb;
      s.we = m2.we;
      s.adr = m2.adr;
      s.dat_w = m2.dat_w;
    end
  end

  // Response only to the winner
  assign m0.ack   = grant[0] && s.ack;
  assign m1.ack   = grant[1] && s.ack;
  assign m2.ack   = grant[2] && s.ack;
  assign m0.dat_r = grant[0] ? s.dat_r : '0;
  assign m1.dat_r = grant[1] ? s.dat_r : '0;
  assign m2.dat_r = grant[2] ? s.dat_r : '0;

  grant_onehot : assert property (
    @(posedge CLK) disable iff (!rst_n) $onehot0(grant)
  ) else $error("wb_arbiter grant not one-hot: %b", grant);

  // An open slave cycle pins the grant for the next edge
  grant_held : assert property (
    @(posedge CLK) disable iff (!rst_n) s.cyc |=> $stable(grant)
  ) else $error("wb_arbiter grant moved during an open cycle");

endmodule

/* verilog/dda_axis.sv */
`timescale 1ns/1ps
`include "motion_defs.svh"

module dda_axis #(
  parameter int AXIS = 0  // Selects this axis's words in each entry
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  wb_if.master                     bus,
  input  logic [`MOTION_SLOTS-1:0] ready,
  input  logic [7:0]               clock_divisor,
  output logic [`MOTION_SLOTS-1:0] finished,
  output logic                     step
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_RUN
  } state_e;

  state_e                       state;
  motion_pkg::slot_t            slot;      // Queue cursor
  motion_pkg::field_e           field;     // Word being fetched
  logic [`MOTION_DW-1:0]        tick_cnt;  // Ticks left, ends at zero
  logic [7:0]                   div_cnt;   // Cycles to next tick
  logic signed [`MOTION_DW-1:0] accum;     // Substep accumulator
  logic signed [`MOTION_DW-1:0] incr;
  logic signed [`MOTION_DW-1:0] incinc;
  logic                         pending;
  logic                         tick;
  logic                         over;      // Step due this tick

  // Slot is ours to run while ready and finished disagree
  assign pending = ready[slot] ^ finished[slot];
  assign tick    = (state == ST_RUN) && (div_cnt == 8'd0);
  assign over    = accum > 0;

  // One burst of three reads, cyc held across it
  assign bus.cyc   = (state == ST_FETCH);
  assign bus.stb   = (state == ST_FETCH);
  assign bus.we    = 1'b0;
  assign bus.dat_w = '0;
  assign bus.adr   = `MOTION_AW'({slot, motion_pkg::axis_t'(AXIS), field});

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      slot     <= '0;
      field    <= motion_pkg::DURATION;
      finished <= '0;
      step     <= 1'b0;
    end else begin
      step <= 1'b0;  // Single cycle pulse
      case (state)
        ST_IDLE: begin
          if (pending) begin
            state <= ST_FETCH;
            field <= motion_pkg::DURATION;
          end
        end
        ST_FETCH: begin
          if (bus.ack) begin
            case (field)
              motion_pkg::DURATION:  field <= motion_pkg::INCREMENT;
              motion_pkg::INCREMENT: field <= motion_pkg::INCINC;
              default:               state <= ST_RUN;  // All words in
            endcase
          end
        end
        ST_RUN: begin
          if (tick) begin
            step <= over;
            if (tick_cnt == '0) begin  // Last tick of the move
              finished[slot] <= ~finished[slot];
              slot           <= slot + 1'b1;
              state          <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Move datapath
  always_ff @(posedge CLK) begin
    if (state == ST_FETCH && bus.ack) begin
      case (field)
        motion_pkg::DURATION:  tick_cnt <= bus.dat_r;
        motion_pkg::INCREMENT: incr     <= bus.dat_r;
        default:               incinc   <= bus.dat_r;
      endcase
      accum   <= '0;             // Fresh start every move
      div_cnt <= clock_divisor;  // First tick divisor+1 cycles out
    end else if (tick) begin
      accum    <= accum + incr - (over ? `MOTION_STEP_THRESHOLD : '0);
      incr     <= incr + incinc;
      tick_cnt <= tick_cnt - 1'b1;
      div_cnt  <= clock_divisor;
    end else if (state == ST_RUN) begin
      div_cnt <= div_cnt - 1'b1;
    end
  end

  // Pulses come only out of a running move
  step_in_run : assert property (
    @(posedge CLK) disable iff (!rst_n) $rose(step) |-> $past(state == ST_RUN)
  ) else $error("dda_axis %0d step outside run phase", AXIS);

endmodule

/* verilog/motion_top.sv */
`timescale 1ns/1ps
`include "motion_defs.svh"

module motion_top (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`MOTION_AW-1:0]    wb_adr,
  input  logic [`MOTION_DW-1:0]    wb_dat_w,
  output logic [`MOTION_DW-1:0]    wb_dat_r,
  output logic                     wb_ack,
  input  logic [7:0]               clock_divisor,
  output logic                     step_0,
  output logic                     step_1,
  output logic [`MOTION_SLOTS-1:0] finished_0,
  output logic [`MOTION_SLOTS-1:0] finished_1
);

  logic [`MOTION_SLOTS-1:0] ready;  // Host queue marks

  wb_if host_bus (.CLK(CLK), .rst_n(rst_n));
  wb_if ax0_bus  (.CLK(CLK), .rst_n(rst_n));
  wb_if ax1_bus  (.CLK(CLK), .rst_n(rst_n));
  wb_if mem_bus  (.CLK(CLK), .rst_n(rst_n));  // Arbiter to buffer

  // Host pins onto master port 0
  assign host_bus.cyc   = wb_cyc;
  assign host_bus.stb   = wb_stb;
  assign host_bus.we    = wb_we;
  assign host_bus.adr   = wb_adr;
  assign host_bus.dat_w = wb_dat_w;
  assign wb_dat_r       = host_bus.dat_r;
  assign wb_ack         = host_bus.ack;

  wb_arbiter wb_arbiter_i (
    .CLK   (CLK),
    .rst_n (rst_n),
    .m0    (host_bus.slave),
    .m1    (ax0_bus.slave),
    .m2    (ax1_bus.slave),
    .s     (mem_bus.master)
  );

  move_buffer move_buffer_i (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .bus        (mem_bus.slave),
    .finished_0 (finished_0),
    .finished_1 (finished_1),
    .ready      (ready)
  );

  dda_axis #(.AXIS(0)) dda_axis_0 (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .bus           (ax0_bus.master),
    .ready         (ready),
    .clock_divisor (clock_divisor),
    .finished      (finished_0),
    .step          (step_0)
  );

  dda_axis #(.AXIS(1)) dda_axis_1 (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .bus           (ax1_bus.master),
    .ready         (ready),
    .clock_divisor (clock_divisor),
    .finished      (finished_1),
    .step          (step_1)
  );

endmodule

/* tb/motion_tb.sv */
`timescale 1ns/1ps
`include "motion_defs.svh"

module motion_tb;

  localparam int WAIT_LIMIT = 4000;  // Cycles allowed for any single wait
  localparam int RAM_WORDS  = `MOTION_SLOTS * `MOTION_AXES * 4;

  logic                     CLK;
  logic                     rst_n;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [`MOTION_AW-1:0]    wb_adr;
  logic [`MOTION_DW-1:0]    wb_dat_w;
  logic [`MOTION_DW-1:0]    wb_dat_r;
  logic                     wb_ack;
  logic [7:0]               clock_divisor;
  logic                     step_0;
  logic                     step_1;
  logic [`MOTION_SLOTS-1:0] finished_0;
  logic [`MOTION_SLOTS-1:0] finished_1;

  logic [31:0]              rng_state;
  logic [`MOTION_DW-1:0]    ram_shadow [RAM_WORDS];  // Last value written per word
  logic [`MOTION_SLOTS-1:0] ready_model = '0;        // Mirror of the ready register
  int                       queued = 0;              // Moves loaded for both axes
  int                       exp_0 [$];               // Model step count per move
  int                       exp_1 [$];
  int                       got_0 [$];               // Observed step count per move
  int                       got_1 [$];
  int                       run_0 = 0;               // Steps in the move underway
  int                       run_1 = 0;
  logic [`MOTION_SLOTS-1:0] prev_fin_0 = '0;
  logic [`MOTION_SLOTS-1:0] prev_fin_1 = '0;

  motion_top motion_top_i (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .clock_divisor (clock_divisor),
    .step_0        (step_0),
    .step_1        (step_1),
    .finished_0    (finished_0),
    .finished_1    (finished_1)
  );

  always #20 CLK = ~CLK;  // 40 ns period

  task automatic report_and_stop(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Steps a move should give with one DDA tick per loop pass
  function automatic int model_steps(input logic [31:0] dur, input logic [31:0] inc,
                                     input logic [31:0] incinc);
    logic signed [31:0] acc;
    logic signed [31:0] rate;
    int                 count;
    acc   = '0;
    rate  = inc;
    count = 0;
    for (int t = 0; t <= int'(dur); t++) begin  // duration+1 ticks
      if (acc > 0) begin
        count++;
        acc = acc + rate - `MOTION_STEP_THRESHOLD;
      end else begin
        acc = acc + rate;
      end
      rate = rate + incinc;
    end
    return count;
  endfunction

  // Entries are slot major with four words per axis
  function automatic logic [`MOTION_AW-1:0] entry_adr(input int slot, input int ax,
                                                      input int fld);
    return `MOTION_AW'((slot * `MOTION_AXES + ax) * 4 + fld);
  endfunction

  function automatic logic [`MOTION_SLOTS-1:0] slot_bit(input int n);
    return `MOTION_SLOTS'(1) << (n % `MOTION_SLOTS);
  endfunction

  // Axis 1 in bits 7:4 and axis 0 in bits 3:0
  function automatic logic [`MOTION_DW-1:0] stat_word(input logic [`MOTION_SLOTS-1:0] f0,
                                                      input logic [`MOTION_SLOTS-1:0] f1);
    return (`MOTION_DW'(f1) << 4) | `MOTION_DW'(f0);
  endfunction

  task automatic bus_access(input logic we, input logic [`MOTION_AW-1:0] adr,
                            input logic [`MOTION_DW-1:0] wdata,
                            output logic [`MOTION_DW-1:0] rdata);
    int n;
    n     = 0;
    rdata = '0;
    @(posedge CLK);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge CLK);
    while (!wb_ack) begin  // Arbitration decides the wait
      n++;
      if (n > WAIT_LIMIT) report_and_stop("host bus access got no ack in time");
      @(negedge CLK);
    end
    rdata = wb_dat_r;
    @(posedge CLK);  // Strobe held through the ack cycle
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_word(input logic [`MOTION_AW-1:0] adr, input logic [`MOTION_DW-1:0] d);
    logic [`MOTION_DW-1:0] unused_rd;
    bus_access(1'b1, adr, d, unused_rd);
  endtask

  task automatic read_word(input logic [`MOTION_AW-1:0] adr, output logic [`MOTION_DW-1:0] d);
    bus_access(1'b0, adr, '0, d);
  endtask

  task automatic read_check(input logic [`MOTION_AW-1:0] adr, input logic [`MOTION_DW-1:0] want);
    logic [`MOTION_DW-1:0] rd;
    read_word(adr, rd);
    assert (rd == want)
      else report_and_stop($sformatf("error: wb_dat_r %h, expected %h", rd, want));
  endtask

  // Same slot for both axes with model counts queued in run order
  task automatic load_move(input int slot, input logic zero_rate, input logic long_1);
    logic [`MOTION_DW-1:0] dur;
    logic [`MOTION_DW-1:0] inc;
    logic [`MOTION_DW-1:0] incinc;
    for (int ax = 0; ax < `MOTION_AXES; ax++) begin
      dur    = next_rand() % 32'd16;  // Short moves
      if (long_1 && ax == 1) dur = 32'd100;  // Axis 1 outlasts axis 0
      inc    = zero_rate ? '0 : (next_rand() & 32'h3FFF_FFFF);
      incinc = zero_rate ? '0 : ((next_rand() & 32'h01FF_FFFF) - 32'h0100_0000);
      write_word(entry_adr(slot, ax, 0), dur);
      write_word(entry_adr(slot, ax, 1), inc);
      write_word(entry_adr(slot, ax, 2), incinc);
      if (ax == 0) exp_0.push_back(model_steps(dur, inc, incinc));
      else exp_1.push_back(model_steps(dur, inc, incinc));
    end
    queued++;
  endtask

  task automatic toggle_ready(input logic [`MOTION_SLOTS-1:0] mask);
    write_word(`MOTION_CTRL_ADR, `MOTION_DW'(mask));
    ready_model = ready_model ^ mask;
  endtask

  task automatic wait_axis0_finished(input logic [`MOTION_SLOTS-1:0] want);
    int n;
    n = 0;
    while (finished_0 != want) begin
      n++;
      if (n > WAIT_LIMIT) report_and_stop("axis 0 did not finish its move in time");
      @(negedge CLK);
    end
  endtask

  task automatic wait_finished(input logic [`MOTION_SLOTS-1:0] want);
    int n;
    n = 0;
    while (finished_0 != want || finished_1 != want) begin
      n++;
      if (n > WAIT_LIMIT) report_and_stop("axes did not finish the queued moves in time");
      @(negedge CLK);
    end
    repeat (2) @(negedge CLK);  // Last step lands with the toggle
  endtask

  task automatic check_counts();
    assert (got_0.size() == queued && got_1.size() == queued)
      else report_and_stop("an axis finished a different number of moves than queued");
    for (int i = 0; i < queued; i++) begin
      assert (got_0[i] == exp_0[i])
        else report_and_stop($sformatf("error: step_0 count %h, expected %h", got_0[i], exp_0[i]));
      assert (got_1[i] == exp_1[i])
        else report_and_stop($sformatf("error: step_1 count %h, expected %h", got_1[i], exp_1[i]));
    end
  endtask

  // Per move step tally and slot order of finish toggles
  always @(negedge CLK) begin
    if (rst_n) begin
      if (step_0) run_0++;
      if (step_1) run_1++;
      if (finished_0 != prev_fin_0) begin
        assert ((finished_0 ^ prev_fin_0) == slot_bit(got_0.size()))
          else report_and_stop($sformatf("error: finished_0 toggle %h, expected %h",
                                         finished_0 ^ prev_fin_0, slot_bit(got_0.size())));
        got_0.push_back(run_0);
        run_0 = 0;
      end
      if (finished_1 != prev_fin_1) begin
        assert ((finished_1 ^ prev_fin_1) == slot_bit(got_1.size()))
          else report_and_stop($sformatf("error: finished_1 toggle %h, expected %h",
                                         finished_1 ^ prev_fin_1, slot_bit(got_1.size())));
        got_1.push_back(run_1);
        run_1 = 0;
      end
      prev_fin_0 = finished_0;
      prev_fin_1 = finished_1;
    end
  end

  ack_one_cycle : assert property (@(posedge CLK) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else report_and_stop("wb_ack stayed high for more than one cycle");

  ack_needs_stb : assert property (
    @(posedge CLK) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb)
  ) else report_and_stop("wb_ack came without an open strobe");

  reset_clear : assert property (
    @(posedge CLK) $rose(rst_n) |->
      (!step_0 && !step_1 && !wb_ack && finished_0 == '0 && finished_1 == '0)
  ) else report_and_stop("outputs were not all low after reset");

  // One slot per finish event
  single_toggle_0 : assert property (
    @(posedge CLK) disable iff (!rst_n)
      (finished_0 != $past(finished_0)) |-> ($countones(finished_0 ^ $past(finished_0)) == 1)
  ) else report_and_stop("finished_0 changed more than one bit at once");

  single_toggle_1 : assert property (
    @(posedge CLK) disable iff (!rst_n)
      (finished_1 != $past(finished_1)) |-> ($countones(finished_1 ^ $past(finished_1)) == 1)
  ) else report_and_stop("finished_1 changed more than one bit at once");

  initial begin
    logic [`MOTION_DW-1:0] rdata;
    int                    polls;
    CLK           = 1'b0;
    rst_n         = 1'b0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    clock_divisor = 8'd3;
    rng_state     = 32'd45;
    repeat (5) @(posedge CLK);
    #2;
    rst_n = 1'b1;

    // RAM write then readback of every word
    for (int a = 0; a < RAM_WORDS; a++) begin
      ram_shadow[a] = next_rand();
      write_word(`MOTION_AW'(a), ram_shadow[a]);
    end
    for (int a = 0; a < RAM_WORDS; a++) read_check(`MOTION_AW'(a), ram_shadow[a]);

    // Axes start at slot 0
    load_move(0, 1'b0, 1'b0);
    toggle_ready(4'b0001);
    wait_finished(ready_model);
    read_check(`MOTION_STAT_ADR, stat_word(ready_model, ready_model));

    // One move at a time and then a move with no rate
    load_move(1, 1'b0, 1'b0);
    toggle_ready(4'b0010);
    wait_finished(ready_model);
    load_move(2, 1'b1, 1'b1);
    toggle_ready(4'b0100);
    wait_axis0_finished(ready_model);
    read_check(`MOTION_STAT_ADR, stat_word(ready_model, ready_model ^ 4'b0100));  // Axis 1 busy
    wait_finished(ready_model);
    assert (got_0[2] == 0 && got_1[2] == 0)
      else report_and_stop("a move with zero rate produced steps");
    check_counts();

    // Full queue ticking every cycle with host polls alongside the fetches
    @(posedge CLK);
    #2;
    clock_divisor = 8'd0;
    load_move(3, 1'b0, 1'b0);
    load_move(0, 1'b0, 1'b0);
    load_move(1, 1'b0, 1'b0);
    load_move(2, 1'b0, 1'b0);
    toggle_ready(4'b1111);
    polls = 0;
    rdata = '0;
    while (rdata != stat_word(ready_model, ready_model)) begin
      polls++;
      if (polls > WAIT_LIMIT) report_and_stop("status word never showed all slots finished");
      read_word(`MOTION_STAT_ADR, rdata);
      assert (rdata[`MOTION_DW-1:8] == '0)
        else report_and_stop($sformatf("error: wb_dat_r %h, status bits above 7 set", rdata));
    end
    wait_finished(ready_model);
    check_counts();

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* compile.f */
+incdir+verilog
verilog/motion_pkg.sv
verilog/wb_if.sv
verilog/move_buffer.sv
verilog/wb_arbiter.sv
verilog/dda_axis.sv
verilog/motion_top.sv
tb/motion_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module motion_tb -f compile.f -o motion_sim
	out=$$(./obj_dir/motion_sim 2>&1); echo "$$out"; echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
